//--- dv/mem_subsys_properties.sv
// Memory stage bus properties

`timescale 1ns/1ps

module mem_subsys_properties (
	input logic                      clk,
	input logic                      rst,
	input logic                      wb_cyc,
	input logic                      wb_stb,
	input logic                      wb_we,
	input logic [3:0]                wb_sel,
	input logic [31:0]               wb_adr,
	input logic [31:0]               wb_dat_w,
	input logic                      wb_ack,
	input logic                      wb_err,
	input logic                      eret,
	input mem_stage_pkg::exc_code_e  exc_code
);

	import mem_stage_pkg::*;

	logic jmp;

	// Same condition that raises exc_jmp_flag in CP0
	assign jmp = (exc_code != EC_NONE) || eret;

	stb_within_cyc: assert property (@(posedge clk) disable iff (rst)
		wb_stb |-> wb_cyc)
		else $error("wb_stb high without wb_cyc");

	request_held: assert property (@(posedge clk) disable iff (rst)
		(wb_stb && !wb_ack && !wb_err) |=> (wb_stb && $stable(wb_we) &&
		$stable(wb_sel) && $stable(wb_adr) && $stable(wb_dat_w)))
		else $error("Wishbone request changed before the answer");

	ack_err_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(wb_ack && wb_err))
		else $error("wb_ack and wb_err high together");

	jump_one_cycle: assert property (@(posedge clk) disable iff (rst)
		jmp |=> !jmp)
		else $error("Exception jump held longer than one cycle");

endmodule

bind mem_stage mem_subsys_properties i_properties (
	.clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
	.wb_sel(wb_sel), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack),
	.wb_err(wb_err), .eret(eret), .exc_code(exc_code)
);

//--- dv/mem_subsys_tb.sv
// Memory subsystem testbench

`timescale 1ns/1ps

module mem_subsys_tb;

	import mem_stage_pkg::*;

	localparam logic [31:0] EXC_VECTOR = 32'h8000_0180;
	localparam int          RAM_WORDS  = 256;
	localparam int          RAM_WAIT   = 2;
	localparam int          N_RANDOM   = 2000;
	localparam int          N_DIRECTED = 24;
	// Twice the worst case of RAM_WAIT+4 cycles per operation plus reset and clear
	localparam longint TIMEOUT_NS = 2 * (N_RANDOM + N_DIRECTED) * (RAM_WAIT + 4) * 8 +
		(4 + 300) * 8;

	logic                  clk;
	logic                  rst;
	mem_opt_e              mem_opt;
	logic [31:0]           mem_addr;
	logic [31:0]           mem_data;
	logic [31:0]           alu_result;
	logic [REG_ADDR_W-1:0] wb_reg_addr_in;
	exc_code_e             exc_code_in;
	logic [31:0]           exc_epc;
	logic [INT_W-1:0]      int_req;
	logic [REG_ADDR_W-1:0] wb_reg_addr;
	logic [31:0]           wb_reg_data;
	logic                  stall;
	logic                  flush;
	logic                  exc_jmp_flag;
	logic [31:0]           exc_jmp_dest;
	logic [INT_W-1:0]      int_ack;

	// Reference model state
	logic [31:0] model_ram [RAM_WORDS];
	logic [31:0] m_status;
	logic [31:0] m_cause;
	logic [31:0] m_epc;
	logic [31:0] m_badvaddr;
	logic [31:0] m_compare;
	int          errors;

	mem_subsys_top #(
		.EXC_VECTOR(EXC_VECTOR), .RAM_WORDS(RAM_WORDS), .RAM_WAIT(RAM_WAIT)
	) i_dut (
		.clk(clk), .rst(rst), .mem_opt(mem_opt), .mem_addr(mem_addr),
		.mem_data(mem_data), .alu_result(alu_result), .wb_reg_addr_in(wb_reg_addr_in),
		.exc_code_in(exc_code_in), .exc_epc(exc_epc), .int_req(int_req),
		.wb_reg_addr(wb_reg_addr), .wb_reg_data(wb_reg_data), .stall(stall),
		.flush(flush), .exc_jmp_flag(exc_jmp_flag), .exc_jmp_dest(exc_jmp_dest),
		.int_ack(int_ack)
	);

	always #4 clk = ~clk;

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("Error: %s = %h, expected %h", name, got, exp);
			$display("Verification failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic drive_idle();
		mem_opt        <= MEM_NONE;
		mem_addr       <= '0;
		mem_data       <= '0;
		alu_result     <= '0;
		wb_reg_addr_in <= '0;
		exc_code_in    <= EC_NONE;
		exc_epc        <= '0;
		int_req        <= '0;
	endtask

	task automatic wait_ready();
		while (stall) begin
			@(posedge clk);
			#1;
		end
	endtask

	function automatic logic [31:0] model_cp0_read(input logic [4:0] reg_num);
		case (reg_num)
			CP0_BADVADDR: return m_badvaddr;
			CP0_COMPARE:  return m_compare;
			CP0_STATUS:   return m_status;
			CP0_CAUSE:    return m_cause;
			CP0_EPC:      return m_epc;
			default:      return 32'd0;
		endcase
	endfunction

	// Check the jump to the vector and record the entry in the model
	task automatic expect_exception(input logic [4:0] code, input logic [7:0] ip,
		input logic [31:0] epc);
		check_val("exc_jmp_flag", 32'(exc_jmp_flag), 32'd1);
		check_val("flush", 32'(flush), 32'd1);
		check_val("exc_jmp_dest", exc_jmp_dest, EXC_VECTOR);
		check_val("wb_reg_addr", 32'(wb_reg_addr), 32'd0);
		m_status[STATUS_EXL] = 1'b1;
		m_cause[15:8]        = ip;
		m_cause[6:2]         = code;
		m_epc                = epc;
	endtask

	task automatic do_op(input mem_opt_e op, input logic [31:0] addr, input logic [31:0] data,
		input logic [4:0] rd, input exc_code_e exc_in, input logic [31:0] epc,
		input logic [7:0] irq);
		logic [31:0] alu;
		logic [7:0]  ip;
		logic        is_word;
		logic        bad;
		int          idx;
		int          lane;
		alu     = $urandom;
		ip      = irq & m_status[15:8];
		is_word = (op == MEM_LW) || (op == MEM_SW);
		bad     = (is_word && addr[1:0] != 2'b00) || (addr >= 32'(RAM_WORDS * 4));
		idx     = int'(addr[9:2]);
		lane    = int'(addr[1:0]);
		@(posedge clk);
		mem_opt        <= op;
		mem_addr       <= addr;
		mem_data       <= data;
		alu_result     <= alu;
		wb_reg_addr_in <= rd;
		exc_code_in    <= exc_in;
		exc_epc        <= epc;
		int_req        <= irq;
		// Accepting edge
		@(posedge clk);
		drive_idle();
		#1;
		if (exc_in != EC_NONE) begin
			check_val("stall", 32'(stall), 32'd0);
			expect_exception(exc_in, 8'h00, epc);
		end else if (m_status[STATUS_IE] && !m_status[STATUS_EXL] && ip != 8'h00) begin
			check_val("int_ack", 32'(int_ack), 32'(ip));
			expect_exception(EC_INT, ip, epc);
		end else begin
			case (op)
				MEM_NONE: begin
					check_val("stall", 32'(stall), 32'd0);
					check_val("flush", 32'(flush), 32'd0);
					check_val("int_ack", 32'(int_ack), 32'd0);
					check_val("wb_reg_addr", 32'(wb_reg_addr), 32'(rd));
					check_val("wb_reg_data", wb_reg_data, alu);
				end
				MEM_MFC0: begin
					check_val("stall", 32'(stall), 32'd0);
					check_val("wb_reg_addr", 32'(wb_reg_addr), 32'(rd));
					check_val("wb_reg_data", wb_reg_data, model_cp0_read(addr[4:0]));
				end
				MEM_MTC0: begin
					check_val("stall", 32'(stall), 32'd1);
					check_val("int_ack", 32'(int_ack),
						(addr[4:0] == CP0_COMPARE) ? 32'h80 : 32'h00);
					wait_ready();
					case (addr[4:0])
						CP0_STATUS:  m_status = data;
						CP0_COMPARE: m_compare = data;
						CP0_EPC:     m_epc = data;
						CP0_CAUSE:   m_cause[9:8] = data[9:8];
						default: ;
					endcase
				end
				MEM_ERET: begin
					check_val("exc_jmp_flag", 32'(exc_jmp_flag), 32'd1);
					check_val("flush", 32'(flush), 32'd0);
					check_val("exc_jmp_dest", exc_jmp_dest, m_epc);
					m_status[STATUS_EXL] = 1'b0;
				end
				default: begin
					check_val("stall", 32'(stall), 32'd1);
					wait_ready();
					if (bad) begin
						expect_exception((op == MEM_LW || op == MEM_LBU) ? EC_ADEL : EC_ADES,
							8'h00, epc);
						m_badvaddr = addr;
					end else begin
						check_val("exc_jmp_flag", 32'(exc_jmp_flag), 32'd0);
						case (op)
							MEM_LW: begin
								check_val("wb_reg_addr", 32'(wb_reg_addr), 32'(rd));
								check_val("wb_reg_data", wb_reg_data, model_ram[idx]);
							end
							MEM_LBU: begin
								check_val("wb_reg_addr", 32'(wb_reg_addr), 32'(rd));
								check_val("wb_reg_data", wb_reg_data,
									{24'd0, model_ram[idx][8*lane +: 8]});
							end
							MEM_SW: begin
								check_val("wb_reg_addr", 32'(wb_reg_addr), 32'd0);
								model_ram[idx] = data;
							end
							default: begin
								check_val("wb_reg_addr", 32'(wb_reg_addr), 32'd0);
								model_ram[idx][8*lane +: 8] = data[7:0];
							end
						endcase
					end
				end
			endcase
		end
	endtask

	// About one address in ten is misaligned or past the RAM
	function automatic logic [31:0] pick_addr(input logic is_word);
		logic [31:0] base;
		base = 32'($urandom_range(RAM_WORDS - 1, 0)) << 2;
		if ($urandom_range(9, 0) == 0) begin
			if (is_word && $urandom_range(1, 0) == 1)
				return base + 32'($urandom_range(3, 1));
			return 32'(RAM_WORDS * 4) + 32'($urandom_range(4095, 0));
		end
		if (is_word)
			return base;
		return base + 32'($urandom_range(3, 0));
	endfunction

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------

	initial begin
		int          sel;
		mem_opt_e    op;
		logic [31:0] addr;
		logic [31:0] data;
		exc_code_e   exc_in;
		logic [7:0]  irq;
		logic [4:0]  cp0_regs_list [6];
		void'($urandom(32'hf72b));
		cp0_regs_list = '{CP0_BADVADDR, CP0_COMPARE, CP0_STATUS, CP0_CAUSE, CP0_EPC,
			CP0_EPC};
		clk = 1'b0;
		rst = 1'b1;
		errors = 0;
		mem_opt = MEM_NONE;
		mem_addr = '0;
		mem_data = '0;
		alu_result = '0;
		wb_reg_addr_in = '0;
		exc_code_in = EC_NONE;
		exc_epc = '0;
		int_req = '0;
		for (int i = 0; i < RAM_WORDS; i++)
			model_ram[i] = '0;
		m_status   = '0;
		m_cause    = '0;
		m_epc      = '0;
		m_badvaddr = '0;
		m_compare  = '1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		// RAM clear sweep
		repeat (300) @(posedge clk);

		// Directed flows
		do_op(MEM_NONE, 32'h0, 32'h0, 5'd3, EC_NONE, 32'h0, 8'h00);
		do_op(MEM_SW, 32'h10, 32'hdead_beef, 5'd0, EC_NONE, 32'h0, 8'h00);
		do_op(MEM_SB, 32'h11, 32'h0000_0055, 5'd0, EC_NONE, 32'h0, 8'h00);
		do_op(MEM_LW, 32'h10, 32'h0, 5'd4, EC_NONE, 32'h0, 8'h00);
		do_op(MEM_LBU, 32'h13, 32'h0, 5'd5, EC_NONE, 32'h0, 8'h00);
		do_op(MEM_LW, 32'h22, 32'h0, 5'd6, EC_NONE, 32'h100, 8'h00);
		do_op(MEM_MFC0, 32'(CP0_CAUSE), 32'h0, 5'd7, EC_NONE, 32'h0, 8'h00);
		do_op(MEM_MFC0, 32'(CP0_BADVADDR), 32'h0, 5'd7, EC_NONE, 32'h0, 8'h00);
		do_op(MEM_SB, 32'h400, 32'h12, 5'd0, EC_NONE, 32'h104, 8'h00);
		do_op(MEM_MFC0, 32'(CP0_CAUSE), 32'h0, 5'd8, EC_NONE, 32'h0, 8'h00);
		do_op(MEM_MFC0, 32'(CP0_BADVADDR), 32'h0, 5'd8, EC_NONE, 32'h0, 8'h00);
		do_op(MEM_NONE, 32'h0, 32'h0, 5'd9, EC_SYS, 32'h0000_1234, 8'h00);
		do_op(MEM_MFC0, 32'(CP0_EPC), 32'h0, 5'd9, EC_NONE, 32'h0, 8'h00);
		do_op(MEM_ERET, 32'h0, 32'h0, 5'd0, EC_NONE, 32'h0, 8'h00);
		do_op(MEM_MTC0, 32'(CP0_STATUS), 32'h0000_0f01, 5'd0, EC_NONE, 32'h0, 8'h00);
		do_op(MEM_NONE, 32'h0, 32'h0, 5'd10, EC_NONE, 32'h200, 8'h04);
		// EXL is now set, so this request is ignored
		do_op(MEM_NONE, 32'h0, 32'h0, 5'd11, EC_NONE, 32'h204, 8'h02);
		do_op(MEM_ERET, 32'h0, 32'h0, 5'd0, EC_NONE, 32'h0, 8'h00);
		do_op(MEM_MTC0, 32'(CP0_COMPARE), 32'h8000_1000, 5'd0, EC_NONE, 32'h0, 8'h00);
		do_op(MEM_MFC0, 32'(CP0_COMPARE), 32'h0, 5'd12, EC_NONE, 32'h0, 8'h00);
		do_op(MEM_MTC0, 32'(CP0_EPC), 32'h0000_4444, 5'd0, EC_NONE, 32'h0, 8'h00);
		do_op(MEM_MFC0, 32'(CP0_EPC), 32'h0, 5'd13, EC_NONE, 32'h0, 8'h00);

		// Random stream weighted toward memory accesses
		for (int n = 0; n < N_RANDOM; n++) begin
			sel    = int'($urandom_range(99, 0));
			data   = $urandom;
			exc_in = EC_NONE;
			irq    = ($urandom_range(9, 0) == 0) ? 8'($urandom_range(127, 1)) : 8'h00;
			if (sel < 30)
				op = MEM_LW;
			else if (sel < 45)
				op = MEM_LBU;
			else if (sel < 65)
				op = MEM_SW;
			else if (sel < 80)
				op = MEM_SB;
			else if (sel < 85)
				op = MEM_NONE;
			else if (sel < 89)
				op = MEM_MFC0;
			else if (sel < 93)
				op = MEM_MTC0;
			else
				op = MEM_ERET;
			addr = pick_addr(op == MEM_LW || op == MEM_SW);
			if (op == MEM_MFC0) begin
				addr = 32'(cp0_regs_list[$urandom_range(5, 0)]);
			end else if (op == MEM_MTC0) begin
				addr = 32'(cp0_regs_list[$urandom_range(5, 1)]);
				// Timer line stays masked and compare stays far above count
				if (addr[4:0] == CP0_STATUS)
					data = {16'd0, 1'b0, data[14:8], 6'd0, data[1:0]};
				else if (addr[4:0] == CP0_COMPARE)
					data[31] = 1'b1;
			end
			// Upstream exceptions land on any kind of operation
			if ($urandom_range(24, 0) == 0)
				exc_in = (data[0]) ? EC_SYS : EC_RI;
			do_op(op, addr, data, 5'($urandom_range(31, 1)), exc_in, $urandom, irq);
		end

		if (errors == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("Verification failed");
			$fatal(1, "Checks reported errors");
		end
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Verification failed");
		$fatal(1, "Simulation timed out");
	end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the memory subsystem simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f \
	--top-module mem_subsys_tb \
	-o mem_subsys_sim

./obj_dir/mem_subsys_sim

//--- sources.f
src/mem_stage_pkg.sv
src/cp0_regs.sv
src/mem_stage.sv
src/wb_data_ram.sv
src/mem_subsys_top.sv
dv/mem_subsys_properties.sv
dv/mem_subsys_tb.sv

//--- src/cp0_regs.sv
// Coprocessor 0 register block

`timescale 1ns/1ps

module cp0_regs #(
	parameter logic [31:0] EXC_VECTOR = 32'h8000_0180
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               count_en,

	// Register write from MTC0
	input  logic [mem_stage_pkg::CP0_ADDR_W-1:0] cp0_write_addr,
	input  logic [31:0]                        cp0_write_data,
	input  logic                               cp0_write_en,

	// Combinational read for MFC0
	input  logic [mem_stage_pkg::CP0_ADDR_W-1:0] cp0_read_addr,
	output logic [31:0]                        cp0_read_data,

	// Exception entry and return
	input  mem_stage_pkg::exc_code_e           exc_code,
	input  logic [mem_stage_pkg::INT_W-1:0]    exc_ip,
	input  logic [31:0]                        exc_epc,
	input  logic [31:0]                        exc_badvaddr,
	input  logic                               eret,

	output logic [31:0]                        status,
	output logic                               timer_pending,
	output logic                               exc_jmp_flag,
	output logic [31:0]                        exc_jmp_dest
);

	import mem_stage_pkg::*;

	logic [31:0] cause;
	logic [31:0] epc;
	logic [31:0] badvaddr;
	logic [31:0] count;
	logic [31:0] compare;

	logic exc_taken;
	logic addr_exc;
	logic count_wr;
	logic compare_wr;
	logic status_wr;
	logic cause_wr;
	logic epc_wr;

	assign exc_taken = (exc_code != EC_NONE);
	assign addr_exc  = (exc_code == EC_ADEL) || (exc_code == EC_ADES);

	assign count_wr   = cp0_write_en && (cp0_write_addr == CP0_COUNT);
	assign compare_wr = cp0_write_en && (cp0_write_addr == CP0_COMPARE);
	assign status_wr  = cp0_write_en && (cp0_write_addr == CP0_STATUS);
	assign cause_wr   = cp0_write_en && (cp0_write_addr == CP0_CAUSE);
	assign epc_wr     = cp0_write_en && (cp0_write_addr == CP0_EPC);

	// Exception entry wins over a pending ERET
	assign exc_jmp_flag = exc_taken || eret;
	assign exc_jmp_dest = exc_taken ? EXC_VECTOR : epc;

	// ------------------------------------------------------------------------
	// Control registers
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			status        <= '0;
			cause         <= '0;
			count         <= '0;
			compare       <= '1;
			timer_pending <= 1'b0;
		end else begin
			if (count_wr)
				count <= cp0_write_data;
			else if (count_en)
				count <= count + 32'd1;

			// Writing compare acknowledges the timer
			if (compare_wr) begin
				compare       <= cp0_write_data;
				timer_pending <= 1'b0;
			end else if (count == compare) begin
				timer_pending <= 1'b1;
			end

			if (exc_taken) begin
				status[STATUS_EXL] <= 1'b1;
				cause[6:2]         <= exc_code;
				cause[15:8]        <= exc_ip;
			end else if (eret) begin
				status[STATUS_EXL] <= 1'b0;
			end else if (status_wr) begin
				status <= cp0_write_data;
			end else if (cause_wr) begin
				// Only the two software interrupt bits are writable
				cause[9:8] <= cp0_write_data[9:8];
			end
		end
	end

	// ------------------------------------------------------------------------
	// Exception payload
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (exc_taken) begin
			epc <= exc_epc;
			if (addr_exc)
				badvaddr <= exc_badvaddr;
		end else if (epc_wr) begin
			epc <= cp0_write_data;
		end
	end

	// Read mux
	always_comb begin
		case (cp0_read_addr)
			CP0_BADVADDR: cp0_read_data = badvaddr;
			CP0_COUNT:    cp0_read_data = count;
			CP0_COMPARE:  cp0_read_data = compare;
			CP0_STATUS:   cp0_read_data = status;
			CP0_CAUSE:    cp0_read_data = cause;
			CP0_EPC:      cp0_read_data = epc;
			default:      cp0_read_data = '0;
		endcase
	end

endmodule

//--- src/mem_stage.sv
// Pipeline memory stage

`timescale 1ns/1ps

module mem_stage (
	input  logic                                 clk,
	input  logic                                 rst,

	// From the execute stage
	input  mem_stage_pkg::mem_opt_e              mem_opt,
	input  logic [31:0]                          mem_addr,
	input  logic [31:0]                          mem_data,
	input  logic [31:0]                          alu_result,
	input  logic [mem_stage_pkg::REG_ADDR_W-1:0] wb_reg_addr_in,
	input  mem_stage_pkg::exc_code_e             exc_code_in,
	input  logic [31:0]                          exc_epc,

	// To writeback
	output logic [mem_stage_pkg::REG_ADDR_W-1:0] wb_reg_addr,
	output logic [31:0]                          wb_reg_data,

	output logic                                 stall,
	output logic                                 flush,

	input  logic [mem_stage_pkg::INT_W-1:0]      int_req,
	output logic [mem_stage_pkg::INT_W-1:0]      int_ack,

	// Wishbone master
	output logic                                 wb_cyc,
	output logic                                 wb_stb,
	output logic                                 wb_we,
	output logic [3:0]                           wb_sel,
	output logic [31:0]                          wb_adr,
	output logic [31:0]                          wb_dat_w,
	input  logic [31:0]                          wb_dat_r,
	input  logic                                 wb_ack,
	input  logic                                 wb_err,

	// CP0 link
	output logic [mem_stage_pkg::CP0_ADDR_W-1:0] cp0_write_addr,
	output logic [31:0]                          cp0_write_data,
	output logic                                 cp0_write_en,
	output logic [mem_stage_pkg::CP0_ADDR_W-1:0] cp0_read_addr,
	input  logic [31:0]                          cp0_read_data,
	output mem_stage_pkg::exc_code_e             exc_code,
	output logic [mem_stage_pkg::INT_W-1:0]      exc_ip,
	output logic [31:0]                          exc_epc_out,
	output logic [31:0]                          exc_badvaddr,
	output logic                                 eret,
	input  logic [31:0]                          status,
	input  logic                                 timer_pending
);

	import mem_stage_pkg::*;

	typedef enum logic {
		READY,
		WAIT
	} state_e;

	state_e state;

	logic [REG_ADDR_W-1:0] wb_reg_addr_latch;
	logic [INT_W-1:0]      timer_vec;
	logic [INT_W-1:0]      int_pending;
	logic                  int_take;
	logic                  byte_access;
	logic [7:0]            load_byte;

	assign stall = (state != READY);
	assign flush = (exc_code != EC_NONE);

	assign cp0_read_addr = mem_addr[CP0_ADDR_W-1:0];

	// ------------------------------------------------------------------------
	// Interrupt detection
	// ------------------------------------------------------------------------

	always_comb begin
		timer_vec            = '0;
		timer_vec[INT_TIMER] = timer_pending;
	end

	assign int_pending = (int_req | timer_vec) & status[15:8];

	// No new interrupt while an entry or a return is still settling
	assign int_take = (|int_pending) && status[STATUS_IE] && !status[STATUS_EXL] &&
		(exc_code == EC_NONE) && !eret;

	// Load lane selection, bus request signals are held during WAIT
	assign byte_access = (wb_sel != 4'b1111);
	assign load_byte   = wb_dat_r[8*wb_adr[1:0] +: 8];

	// ------------------------------------------------------------------------
	// Stage sequencer
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		// Single cycle pulses
		int_ack      <= '0;
		cp0_write_en <= 1'b0;
		eret         <= 1'b0;

		if (rst) begin
			state       <= READY;
			exc_code    <= EC_NONE;
			exc_ip      <= '0;
			wb_reg_addr <= '0;
			wb_cyc      <= 1'b0;
			wb_stb      <= 1'b0;
		end else begin
			case (state)
				READY: begin
					exc_code          <= EC_NONE;
					exc_ip            <= '0;
					exc_epc_out       <= exc_epc;
					exc_badvaddr      <= mem_addr;
					wb_reg_addr_latch <= wb_reg_addr_in;
					if (exc_code_in != EC_NONE) begin
						exc_code    <= exc_code_in;
						wb_reg_addr <= '0;
					end else if (int_take) begin
						exc_code    <= EC_INT;
						exc_ip      <= int_pending;
						int_ack     <= int_pending;
						wb_reg_addr <= '0;
					end else begin
						wb_reg_addr <= wb_reg_addr_in;
						wb_reg_data <= alu_result;
						case (mem_opt)
							MEM_MFC0: wb_reg_data <= cp0_read_data;
							MEM_MTC0: begin
								state          <= WAIT;
								cp0_write_en   <= 1'b1;
								cp0_write_addr <= mem_addr[CP0_ADDR_W-1:0];
								cp0_write_data <= mem_data;
								// Compare write clears the timer line
								if (mem_addr[CP0_ADDR_W-1:0] == CP0_COMPARE)
									int_ack[INT_TIMER] <= 1'b1;
							end
							MEM_ERET: eret <= 1'b1;
							MEM_LW, MEM_LBU, MEM_SW, MEM_SB: begin
								state       <= WAIT;
								wb_cyc      <= 1'b1;
								wb_stb      <= 1'b1;
								wb_we       <= (mem_opt == MEM_SW) || (mem_opt == MEM_SB);
								wb_adr      <= mem_addr;
								wb_reg_addr <= '0;
								if (mem_opt == MEM_LW || mem_opt == MEM_SW) begin
									wb_sel   <= 4'b1111;
									wb_dat_w <= mem_data;
								end else begin
									wb_sel   <= 4'b0001 << mem_addr[1:0];
									wb_dat_w <= {4{mem_data[7:0]}};
								end
							end
							default: ;
						endcase
					end
				end

				WAIT: begin
					if (!wb_cyc) begin
						// MTC0 has reached CP0
						state <= READY;
					end else if (wb_err) begin
						state        <= READY;
						wb_cyc       <= 1'b0;
						wb_stb       <= 1'b0;
						exc_badvaddr <= wb_adr;
						if (wb_we)
							exc_code <= EC_ADES;
						else
							exc_code <= EC_ADEL;
					end else if (wb_ack) begin
						state  <= READY;
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						if (!wb_we) begin
							wb_reg_addr <= wb_reg_addr_latch;
							wb_reg_data <= byte_access ? {24'd0, load_byte} : wb_dat_r;
						end
					end
				end

				default: state <= READY;
			endcase
		end
	end

endmodule

//--- src/mem_stage_pkg.sv
// Memory stage shared definitions

package mem_stage_pkg;

	// ------------------------------------------------------------------------
	// Operations handed over by the execute stage
	// ------------------------------------------------------------------------

	typedef enum logic [2:0] {
		MEM_NONE = 3'd0,
		MEM_LW   = 3'd1,
		MEM_LBU  = 3'd2,
		MEM_SW   = 3'd3,
		MEM_SB   = 3'd4,
		MEM_MFC0 = 3'd5,
		MEM_MTC0 = 3'd6,
		MEM_ERET = 3'd7
	} mem_opt_e;

	// ------------------------------------------------------------------------
	// Exception codes, MIPS cause encoding
	// ------------------------------------------------------------------------

	typedef enum logic [4:0] {
		EC_INT  = 5'd0,
		EC_ADEL = 5'd4,
		EC_ADES = 5'd5,
		EC_SYS  = 5'd8,
		EC_RI   = 5'd10,
		EC_NONE = 5'd31
	} exc_code_e;

	// ------------------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------------------

	localparam int CP0_ADDR_W = 5;
	localparam int REG_ADDR_W = 5;

	// Interrupt lines map onto status[15:8] and cause[15:8]
	localparam int INT_W     = 8;
	localparam int INT_TIMER = 7;

	// ------------------------------------------------------------------------
	// CP0 register numbers
	// ------------------------------------------------------------------------

	localparam logic [4:0] CP0_BADVADDR = 5'd8;
	localparam logic [4:0] CP0_COUNT    = 5'd9;
	localparam logic [4:0] CP0_COMPARE  = 5'd11;
	localparam logic [4:0] CP0_STATUS   = 5'd12;
	localparam logic [4:0] CP0_CAUSE    = 5'd13;
	localparam logic [4:0] CP0_EPC      = 5'd14;

	// Status bit positions
	localparam int STATUS_IE  = 0;
	localparam int STATUS_EXL = 1;

endpackage

//--- src/mem_subsys_top.sv
// Memory subsystem top level

`timescale 1ns/1ps

module mem_subsys_top #(
	parameter logic [31:0] EXC_VECTOR = 32'h8000_0180,
	parameter int          RAM_WORDS  = 256,
	parameter int          RAM_WAIT   = 2
) (
	input  logic                                 clk,
	input  logic                                 rst,
	input  mem_stage_pkg::mem_opt_e              mem_opt,
	input  logic [31:0]                          mem_addr,
	input  logic [31:0]                          mem_data,
	input  logic [31:0]                          alu_result,
	input  logic [mem_stage_pkg::REG_ADDR_W-1:0] wb_reg_addr_in,
	input  mem_stage_pkg::exc_code_e             exc_code_in,
	input  logic [31:0]                          exc_epc,
	input  logic [mem_stage_pkg::INT_W-1:0]      int_req,
	output logic [mem_stage_pkg::REG_ADDR_W-1:0] wb_reg_addr,
	output logic [31:0]                          wb_reg_data,
	output logic                                 stall,
	output logic                                 flush,
	output logic                                 exc_jmp_flag,
	output logic [31:0]                          exc_jmp_dest,
	output logic [mem_stage_pkg::INT_W-1:0]      int_ack
);

	import mem_stage_pkg::*;

	// Wishbone
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [3:0]  wb_sel;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;
	logic        wb_err;

	// CP0 link
	logic [CP0_ADDR_W-1:0] cp0_write_addr;
	logic [31:0]           cp0_write_data;
	logic                  cp0_write_en;
	logic [CP0_ADDR_W-1:0] cp0_read_addr;
	logic [31:0]           cp0_read_data;
	exc_code_e             exc_code;
	logic [INT_W-1:0]      exc_ip;
	logic [31:0]           exc_epc_out;
	logic [31:0]           exc_badvaddr;
	logic                  eret;
	logic [31:0]           status;
	logic                  timer_pending;

	mem_stage i_mem_stage (
		.clk(clk), .rst(rst),
		.mem_opt(mem_opt), .mem_addr(mem_addr), .mem_data(mem_data),
		.alu_result(alu_result), .wb_reg_addr_in(wb_reg_addr_in),
		.exc_code_in(exc_code_in), .exc_epc(exc_epc),
		.wb_reg_addr(wb_reg_addr), .wb_reg_data(wb_reg_data),
		.stall(stall), .flush(flush), .int_req(int_req), .int_ack(int_ack),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_sel(wb_sel),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack), .wb_err(wb_err),
		.cp0_write_addr(cp0_write_addr), .cp0_write_data(cp0_write_data),
		.cp0_write_en(cp0_write_en), .cp0_read_addr(cp0_read_addr),
		.cp0_read_data(cp0_read_data), .exc_code(exc_code), .exc_ip(exc_ip),
		.exc_epc_out(exc_epc_out), .exc_badvaddr(exc_badvaddr), .eret(eret),
		.status(status), .timer_pending(timer_pending)
	);

	// Count stops while the stage is stalled
	cp0_regs #(.EXC_VECTOR(EXC_VECTOR)) i_cp0_regs (
		.clk(clk), .rst(rst), .count_en(!stall),
		.cp0_write_addr(cp0_write_addr), .cp0_write_data(cp0_write_data),
		.cp0_write_en(cp0_write_en), .cp0_read_addr(cp0_read_addr),
		.cp0_read_data(cp0_read_data), .exc_code(exc_code), .exc_ip(exc_ip),
		.exc_epc(exc_epc_out), .exc_badvaddr(exc_badvaddr), .eret(eret),
		.status(status), .timer_pending(timer_pending),
		.exc_jmp_flag(exc_jmp_flag), .exc_jmp_dest(exc_jmp_dest)
	);

	wb_data_ram #(.RAM_WORDS(RAM_WORDS), .RAM_WAIT(RAM_WAIT)) i_wb_data_ram (
		.clk(clk), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_sel(wb_sel),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack), .wb_err(wb_err)
	);

endmodule

//--- src/wb_data_ram.sv
// Wishbone data RAM

`timescale 1ns/1ps

module wb_data_ram #(
	parameter int RAM_WORDS = 256,
	parameter int RAM_WAIT  = 2
) (
	input  logic        clk,
	input  logic        rst,

	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [3:0]  wb_sel,
	input  logic [31:0] wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic        wb_ack,
	output logic        wb_err
);

	localparam int IDX_W  = $clog2(RAM_WORDS);
	localparam int WAIT_W = $clog2(RAM_WAIT + 2);
	localparam logic [31:0] RAM_BYTES = 32'(RAM_WORDS * 4);

	logic [31:0] mem [RAM_WORDS];

	logic [WAIT_W-1:0] wait_cnt;
	logic [IDX_W-1:0]  clr_idx;
	logic              clr_busy;
	logic [IDX_W-1:0]  word_idx;
	logic              req;
	logic              answer;
	logic              bad_addr;

	assign word_idx = wb_adr[IDX_W+1:2];

	// A request is served only once the clear sweep is over
	assign req    = wb_cyc && wb_stb && !wb_ack && !wb_err && !clr_busy;
	assign answer = req && (wait_cnt == WAIT_W'(RAM_WAIT));

	// Misaligned full word, or past the end of the array
	assign bad_addr = ((wb_sel == 4'b1111) && (wb_adr[1:0] != 2'b00)) ||
		(wb_adr >= RAM_BYTES);

	// ------------------------------------------------------------------------
	// Handshake and clear sweep
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			wait_cnt <= '0;
			clr_idx  <= '0;
			clr_busy <= 1'b1;
			wb_ack   <= 1'b0;
			wb_err   <= 1'b0;
		end else begin
			wb_ack <= answer && !bad_addr;
			wb_err <= answer && bad_addr;
			if (answer)
				wait_cnt <= '0;
			else if (req)
				wait_cnt <= wait_cnt + 1'b1;
			if (clr_busy) begin
				clr_idx <= clr_idx + 1'b1;
				if (clr_idx == IDX_W'(RAM_WORDS - 1))
					clr_busy <= 1'b0;
			end
		end
	end

	// Storage with byte lanes
	always_ff @(posedge clk) begin
		if (clr_busy) begin
			mem[clr_idx] <= '0;
		end else if (answer && !bad_addr && wb_we) begin
			for (int b = 0; b < 4; b++)
				if (wb_sel[b])
					mem[word_idx][8*b +: 8] <= wb_dat_w[8*b +: 8];
		end
		if (answer && !wb_we)
			wb_dat_r <= mem[word_idx];
	end

endmodule
